/* rtl/audio_pkg.sv */
// Rates assume one shared system clock; credit_depth and 2*i2s_word_bits must be powers of two

package audio_pkg;

    //------------------------------
    // SPI side, PMOD MIC3
    //------------------------------

    localparam int spi_half_period  = 4;    // Clocks per sck half period
    localparam int spi_frame_bits   = 16;
    localparam int spi_gap_cycles   = 160;  // cs high between frames, 288 cycles per sample

    //------------------------------
    // I2S side
    //------------------------------

    localparam int bclk_half_period = 4;
    localparam int i2s_word_bits    = 16;   // 256 clocks per stereo frame

    //------------------------------
    // Datapath
    //------------------------------

    localparam int credit_depth     = 4;    // Buffer entries and initial credits
    localparam int base_shift       = 4;    // 12-bit ADC onto 16-bit audio
    localparam int gain_bits        = 2;

    // Frame as shifted in, or split into its fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [3:0]  lead_zeros;        // Must read as zero on a good frame
            logic [11:0] adc_sample;        // Unsigned, mid-scale at 2048
        } fields;
    } mic_frame_u;

    typedef logic signed [15:0] audio_sample_t;

endpackage

/* rtl/sample_if.sv */
// Credit link with no back-pressure after decode; the decoder must honor the credit count
`timescale 1ns/1ns

interface sample_if;

    logic                      dec_valid;
    logic [11:0]               dec_sample;     // Raw ADC code
    logic                      out_valid;
    audio_pkg::audio_sample_t  out_word;
    logic                      credit_return;  // One pulse per buffer pop

    modport decode (
        output dec_valid,
        output dec_sample,
        input  credit_return
    );

    modport execute (
        input  dec_valid,
        input  dec_sample,
        output out_valid,
        output out_word
    );

    modport result (
        input  out_valid,
        input  out_word,
        output credit_return
    );

endinterface

/* rtl/mic3_spi_receiver.sv */
// SPI master for one ADC only; sdo must be stable at each rising sck, frames are not checked here
`timescale 1ns/1ns

module mic3_spi_receiver (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sdo,
    output logic                   cs,
    output logic                   sck,
    output logic                   frame_valid,
    output audio_pkg::mic_frame_u  frame
);

    logic                                               in_xfer;
    logic [$clog2(audio_pkg::spi_gap_cycles)-1:0]       gap_cnt;
    logic [$clog2(audio_pkg::spi_half_period)-1:0]      half_cnt;
    logic [$clog2(audio_pkg::spi_frame_bits)-1:0]       bit_cnt;
    logic [audio_pkg::spi_frame_bits-1:0]               shift_q;
    logic                                               half_done;
    logic                                               sck_rise;

    assign half_done = in_xfer && (half_cnt == audio_pkg::spi_half_period - 1);
    assign sck_rise  = half_done && !sck;

    //------------------------------
    // Gap and transfer sequencing
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_xfer     <= 1'b0;
            gap_cnt     <= '0;
            half_cnt    <= '0;
            bit_cnt     <= '0;
            sck         <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (!in_xfer) begin
                if (gap_cnt == audio_pkg::spi_gap_cycles - 1) begin
                    gap_cnt <= '0;
                    in_xfer <= 1'b1;                       // cs falls next
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end else if (half_done) begin
                half_cnt <= '0;
                sck      <= !sck;
                if (!sck) begin
                    // Last bit lands in shift_q on this same edge
                    frame_valid <= (bit_cnt == audio_pkg::spi_frame_bits - 1);
                end else if (bit_cnt == audio_pkg::spi_frame_bits - 1) begin
                    bit_cnt <= '0;
                    in_xfer <= 1'b0;                       // sck low and cs high together
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            shift_q <= {shift_q[audio_pkg::spi_frame_bits-2:0], sdo};
        end
    end

    assign cs        = !in_xfer;
    assign frame.raw = shift_q;

endmodule

/* rtl/mic_frame_decoder.sv */
// Good frames arriving without credit are dropped, not held; both error flags clear only on reset
`timescale 1ns/1ns

module mic_frame_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_valid,
    input  audio_pkg::mic_frame_u  frame,
    sample_if.decode               link,
    output logic                   frame_error,
    output logic                   overrun
);

    logic [$clog2(audio_pkg::credit_depth+1)-1:0]  credits;
    logic                                          frame_good;
    logic                                          send;

    assign frame_good = (frame.fields.lead_zeros == 4'd0);
    assign send       = frame_valid && frame_good && (credits != '0);

    //------------------------------
    // Credits and status
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits        <= $bits(credits)'(audio_pkg::credit_depth);
            link.dec_valid <= 1'b0;
            frame_error    <= 1'b0;
            overrun        <= 1'b0;
        end else begin
            link.dec_valid <= send;

            // Spend and return may meet in one cycle
            case ({send, link.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            if (frame_valid && !frame_good) begin
                frame_error <= 1'b1;                       // Sticky
            end
            if (frame_valid && frame_good && (credits == '0)) begin
                overrun <= 1'b1;                           // Sample lost
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            link.dec_sample <= frame.fields.adc_sample;
        end
    end

endmodule

/* rtl/gain_stage.sv */
// Gain is read with each sample, so a key change takes effect on the next sample only
`timescale 1ns/1ns

module gain_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [audio_pkg::gain_bits-1:0]  gain,
    sample_if.execute                        link
);

    logic signed [12:0]        centered;
    logic signed [19:0]        scaled;     // Worst case shift is 7
    audio_pkg::audio_sample_t  clamped;

    //------------------------------
    // Offset, scale, saturate
    //------------------------------

    // Mid-scale of the 12-bit ADC becomes zero
    assign centered = $signed({1'b0, link.dec_sample}) - 13'sd2048;

    assign scaled = {{7{centered[12]}}, centered} << (audio_pkg::base_shift + gain);

    always_comb begin
        if (scaled[19:15] == {5{scaled[15]}}) begin
            clamped = scaled[15:0];                        // Fits in 16 bits
        end else if (scaled[19]) begin
            clamped = 16'sh8000;
        end else begin
            clamped = 16'sh7fff;
        end
    end

    //------------------------------
    // Output register
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link.out_valid <= 1'b0;
        end else begin
            link.out_valid <= link.dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (link.dec_valid) begin
            link.out_word <= clamped;
        end
    end

endmodule

/* rtl/i2s_transmitter.sv */
// Buffer relies on upstream credits and never checks for full; bclk_half_period must be at least 2
`timescale 1ns/1ns

module i2s_transmitter (
    input  logic        clk,
    input  logic        rst_n,
    sample_if.result    link,
    output logic        bclk,
    output logic        lrclk,
    output logic        sdata
);

    audio_pkg::audio_sample_t                        mem [audio_pkg::credit_depth];
    logic [$clog2(audio_pkg::credit_depth)-1:0]      wr_ptr;
    logic [$clog2(audio_pkg::credit_depth)-1:0]      rd_ptr;
    logic [$clog2(audio_pkg::credit_depth+1)-1:0]    count;
    logic [$clog2(audio_pkg::bclk_half_period)-1:0]  half_cnt;
    logic [$clog2(2*audio_pkg::i2s_word_bits)-1:0]   slot;
    logic [$clog2(2*audio_pkg::i2s_word_bits)-1:0]   slot_next;
    audio_pkg::audio_sample_t                        cur_word;
    audio_pkg::audio_sample_t                        shift_q;
    audio_pkg::audio_sample_t                        head;
    logic                                            fall;
    logic                                            pre_fall;
    logic                                            left_load;
    logic                                            right_load;
    logic                                            pop;

    assign fall       = bclk && (half_cnt == audio_pkg::bclk_half_period - 1);
    assign pre_fall   = bclk && (half_cnt == audio_pkg::bclk_half_period - 2);
    assign slot_next  = slot + 1'b1;
    assign left_load  = pre_fall && (slot == '0);      // Just before left MSB goes out
    assign right_load = pre_fall && (slot == audio_pkg::i2s_word_bits);
    assign pop        = left_load && (count != '0);
    assign head       = pop ? mem[rd_ptr] : '0;        // Zero fill on underrun

    //------------------------------
    // Bit clock, word select, data
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_cnt      <= '0;
            bclk          <= 1'b0;
            slot          <= '0;
            lrclk         <= 1'b0;
            sdata         <= 1'b0;
            link.credit_return <= 1'b0;
        end else begin
            link.credit_return <= pop;
            if (half_cnt == audio_pkg::bclk_half_period - 1) begin
                half_cnt <= '0;
                bclk     <= !bclk;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            if (fall) begin
                slot  <= slot_next;
                lrclk <= (slot_next >= audio_pkg::i2s_word_bits);  // High for right word
                sdata <= shift_q[15];                              // Lags lrclk by one bit
            end
        end
    end

    //------------------------------
    // Sample buffer
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (link.out_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({link.out_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (link.out_valid) begin
            mem[wr_ptr] <= link.out_word;
        end
        if (left_load) begin
            cur_word <= head;
            shift_q  <= head;
        end else if (right_load) begin
            shift_q <= cur_word;                          // Same word on both channels
        end else if (fall) begin
            shift_q <= shift_q << 1;
        end
    end

endmodule

/* rtl/audio_loop_top.sv */
// Core only; board pin inversion, MCLK and other board outputs live in the wrapper
`timescale 1ns/1ns

module audio_loop_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [audio_pkg::gain_bits-1:0]  gain,
    input  logic                             mic_sdo,
    output logic                             mic_cs,
    output logic                             mic_sck,
    output logic                             i2s_bclk,
    output logic                             i2s_lrclk,
    output logic                             i2s_sdata,
    output logic                             frame_error,
    output logic                             overrun
);

    logic                   frame_valid;
    audio_pkg::mic_frame_u  mic_frame;

    sample_if link ();

    //------------------------------

    mic3_spi_receiver i_spi_receiver (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sdo         ( mic_sdo     ),
        .cs          ( mic_cs      ),
        .sck         ( mic_sck     ),
        .frame_valid ( frame_valid ),
        .frame       ( mic_frame   )
    );

    mic_frame_decoder i_decoder (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .frame_valid ( frame_valid ),
        .frame       ( mic_frame   ),
        .link        ( link        ),
        .frame_error ( frame_error ),
        .overrun     ( overrun     )
    );

    gain_stage i_gain (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .gain  ( gain  ),
        .link  ( link  )
    );

    i2s_transmitter i_i2s (
        .clk   ( clk       ),
        .rst_n ( rst_n     ),
        .link  ( link      ),
        .bclk  ( i2s_bclk  ),
        .lrclk ( i2s_lrclk ),
        .sdata ( i2s_sdata )   // To DAC, no MCLK needed
    );

endmodule

/* verification/audio_loop_assert.sv */
// Bound to the decoder and the SPI receiver, with the inputs of the other block tied to idle values
`timescale 1ns/1ns

module audio_loop_assert (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [$clog2(audio_pkg::credit_depth+1)-1:0]  credits,
    input  logic                                          dec_valid,
    input  logic                                          credit_return,
    input  logic                                          cs,
    input  logic                                          sck
);

    logic [4:0]                                    sck_rises;     // Rising sck edges in the current cs low window
    logic                                          sck_q;
    logic [$clog2(audio_pkg::credit_depth+1)-1:0]  link_credits;  // Counted from link traffic only

    always_ff @(posedge clk) begin
        sck_q <= sck;
        if (!rst_n || cs) begin
            sck_rises <= '0;
        end else if (sck && !sck_q) begin
            sck_rises <= sck_rises + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_credits <= $bits(link_credits)'(audio_pkg::credit_depth);
        end else begin
            case ({dec_valid, credit_return})
                2'b10:   link_credits <= link_credits - 1'b1;
                2'b01:   link_credits <= link_credits + 1'b1;
                default: link_credits <= link_credits;
            endcase
        end
    end

    credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= audio_pkg::credit_depth)
        else $error("credit count above the buffer depth");

    no_send_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> (link_credits != '0))
        else $error("sample sent while no credit was left on the link");

    cs_frame_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cs) |-> (sck_rises == 5'd16))
        else $error("chip select low for other than 16 serial clock periods");

endmodule

bind mic_frame_decoder audio_loop_assert credit_checks (
    .clk           ( clk                ),
    .rst_n         ( rst_n              ),
    .credits       ( credits            ),
    .dec_valid     ( link.dec_valid     ),
    .credit_return ( link.credit_return ),
    .cs            ( 1'b1               ),
    .sck           ( 1'b0               )
);

bind mic3_spi_receiver audio_loop_assert spi_checks (
    .clk           ( clk   ),
    .rst_n         ( rst_n ),
    .credits       ( 3'd0  ),
    .dec_valid     ( 1'b0  ),
    .credit_return ( 1'b0  ),
    .cs            ( cs    ),
    .sck           ( sck   )
);

/* verification/audio_loop_tb.sv */
// Directed tests; the mic model sends mid-scale frames, which play as silence, when its queue is empty
`timescale 1ns/1ns

module audio_loop_tb;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic [audio_pkg::gain_bits-1:0]  gain;
    logic                             mic_sdo = 1'b0;
    logic                             mic_cs;
    logic                             mic_sck;
    logic                             i2s_bclk;
    logic                             i2s_lrclk;
    logic                             i2s_sdata;
    logic                             frame_error;
    logic                             overrun;

    logic [15:0]               mic_q [$];           // Frames waiting for the mic model
    audio_pkg::audio_sample_t  exp_q [$];
    logic [31:0]               pair_q [$];          // Left and right words from the I2S monitor
    logic [15:0]               mic_word = 16'h0800;
    int                        bit_idx = 0;
    logic                      cs_q = 1'b1;
    logic                      sck_q = 1'b0;
    logic [15:0]               acc = '0;
    logic                      lr_prev = 1'b0;
    audio_pkg::audio_sample_t  left_word = '0;
    int                        errors = 0;
    int                        seed = 44727;
    int                        cycles = 0;
    int                        wait_start = 0;
    int                        wait_limit = 2000;
    int                        group_frames = 0;

    audio_loop_top audio_loop_top_i (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .gain        ( gain        ),
        .mic_sdo     ( mic_sdo     ),
        .mic_cs      ( mic_cs      ),
        .mic_sck     ( mic_sck     ),
        .i2s_bclk    ( i2s_bclk    ),
        .i2s_lrclk   ( i2s_lrclk   ),
        .i2s_sdata   ( i2s_sdata   ),
        .frame_error ( frame_error ),
        .overrun     ( overrun     )
    );

    always #50 clk = !clk;

    // ------------------------------
    // PMOD MIC3 model and I2S monitor
    // ------------------------------

    always @(posedge clk) begin
        #1;
        if (!cs_q && mic_cs) begin
            mic_word = (mic_q.size() != 0) ? mic_q.pop_front() : 16'h0800;
        end else if (cs_q && !mic_cs) begin
            bit_idx = 15;
            mic_sdo = mic_word[15];                        // MSB ready before first sck rise
        end else if (!mic_cs && sck_q && !mic_sck && bit_idx > 0) begin
            bit_idx = bit_idx - 1;
            mic_sdo = mic_word[bit_idx];
        end
        cs_q  = mic_cs;
        sck_q = mic_sck;
    end

    // LSB of a word arrives on the first rising bclk after the lrclk edge
    always @(posedge i2s_bclk) begin
        if (i2s_lrclk != lr_prev) begin
            if (lr_prev) begin
                pair_q.push_back({left_word, acc[14:0], i2s_sdata});
            end else begin
                left_word = {acc[14:0], i2s_sdata};
            end
            acc = '0;
        end else begin
            acc = {acc[14:0], i2s_sdata};
        end
        lr_prev = i2s_lrclk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles - wait_start > wait_limit) begin
            $display("Timeout: no expected output word within %0d cycles", wait_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Reference model and compares
    // ------------------------------

    function automatic audio_pkg::audio_sample_t expected_word(input logic [11:0] sample,
                                                               input logic [1:0]  g);
        int value;
        value = (int'(sample) - 2048) * (1 << (audio_pkg::base_shift + int'(g)));
        if (value > 32767) begin
            value = 32767;
        end else if (value < -32768) begin
            value = -32768;
        end
        return value[15:0];
    endfunction

    function automatic logic [11:0] random_sample();
        logic [11:0] s;
        s = 12'd2048;
        while (s == 12'd2048) begin                        // Mid-scale would play as silence
            s = 12'($unsigned($random(seed)));
        end
        return s;
    endfunction

    task automatic check_word(input string name, input audio_pkg::audio_sample_t expected,
                              input audio_pkg::audio_sample_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic set_gain(input logic [1:0] g);
        @(posedge clk);
        #1;
        gain = g;
    endtask

    task automatic queue_frame(input logic [15:0] frame);
        mic_q.push_back(frame);
        group_frames++;
        if (frame[15:12] == 4'h0) begin                    // Bad frames give no word
            exp_q.push_back(expected_word(frame[11:0], gain));
        end
    endtask

    task automatic next_output(output audio_pkg::audio_sample_t left,
                               output audio_pkg::audio_sample_t right);
        logic [31:0] pair;
        pair = '0;
        while (pair == '0) begin                           // Skip underrun fill
            while (pair_q.size() == 0) begin
                @(posedge clk);
            end
            pair = pair_q.pop_front();
        end
        left  = pair[31:16];
        right = pair[15:0];
    endtask

    task automatic collect_words(input string name);
        audio_pkg::audio_sample_t left;
        audio_pkg::audio_sample_t right;
        audio_pkg::audio_sample_t expected;
        wait_limit = 300 * group_frames + 2000;
        wait_start = cycles;
        while (exp_q.size() != 0) begin
            expected = exp_q.pop_front();
            next_output(left, right);
            check_word(name, expected, left);
            check_word(name, expected, right);
        end
        group_frames = 0;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic idle_after_reset();
        logic [31:0] pair;
        check_flag("reset_cs", 1'b1, mic_cs);
        check_flag("reset_sck", 1'b0, mic_sck);
        check_flag("reset_bclk", 1'b0, i2s_bclk);
        check_flag("reset_lrclk", 1'b0, i2s_lrclk);
        check_flag("reset_sdata", 1'b0, i2s_sdata);
        check_flag("reset_frame_error", 1'b0, frame_error);
        check_flag("reset_overrun", 1'b0, overrun);
        wait_start = cycles;
        repeat (2) begin
            while (pair_q.size() == 0) begin
                @(posedge clk);
            end
            pair = pair_q.pop_front();
            check_word("reset_words", '0, pair[31:16]);
            check_word("reset_words", '0, pair[15:0]);
        end
    endtask

    task automatic play_random_frames();
        set_gain(2'd0);
        repeat (10) begin
            queue_frame({4'h0, random_sample()});
        end
        collect_words("random_gain0");
    endtask

    task automatic sweep_gain_extremes();
        logic [11:0] samples [6];
        int          g;
        samples = '{12'd0, 12'd4095, 12'd2049, 12'd2040, 12'd3071, 12'd1024};
        for (g = 1; g <= 3; g++) begin
            set_gain(2'(g));
            foreach (samples[i]) begin
                queue_frame({4'h0, samples[i]});
            end
            collect_words("gain_extremes");
        end
    endtask

    task automatic reject_bad_frame();
        set_gain(2'd1);
        check_flag("frame_error_before", 1'b0, frame_error);
        queue_frame(16'h5a5a);                             // Nonzero leading bits
        queue_frame({4'h0, 12'd2100});
        queue_frame({4'h0, 12'd1900});
        queue_frame({4'h0, random_sample()});
        collect_words("bad_frame");
        check_flag("frame_error", 1'b1, frame_error);
    endtask

    task automatic run_long_stream();
        set_gain(2'd2);
        repeat (20) begin
            queue_frame({4'h0, random_sample()});
        end
        collect_words("long_run");
        check_flag("overrun", 1'b0, overrun);
        check_flag("frame_error_sticky", 1'b1, frame_error);
    endtask

    initial begin
        rst_n = 1'b0;
        gain  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_after_reset();
        play_random_frames();
        sweep_gain_extremes();
        reject_bad_frame();
        run_long_stream();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* audio_loop_top.f */
rtl/audio_pkg.sv
rtl/sample_if.sv
rtl/mic3_spi_receiver.sv
rtl/mic_frame_decoder.sv
rtl/gain_stage.sv
rtl/i2s_transmitter.sv
rtl/audio_loop_top.sv
verification/audio_loop_assert.sv
verification/audio_loop_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module audio_loop_tb \
    -f audio_loop_top.f -o audio_loop_sim \
    && ./obj_dir/audio_loop_sim 2>&1 | tee sim.log \
    && grep -q "^Result: PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
